/* agen_defs.svh */
`ifndef AGEN_DEFS_SVH
`define AGEN_DEFS_SVH

// Architectural register counts
`define AGEN_NUM_GPR 8
`define AGEN_NUM_SEG 8
`define AGEN_NUM_MM 8

// Three lane bits per GPR for the low byte, the high byte and the upper word
`define AGEN_GPR_SB_W (`AGEN_NUM_GPR * 3)

// Younger stages AG2, ME, ME2 and EX tracked for dependencies
`define AGEN_INFLIGHT 4

// Interrupt descriptor entry addresses
`define AGEN_NMI_VECTOR 32'h0000_0010
`define AGEN_PF_VECTOR 32'h0000_0070
`define AGEN_GP_VECTOR 32'h0000_0068

`endif

/* agen_pkg.sv */
`default_nettype none
`include "agen_defs.svh"

package agen_pkg;

   typedef logic [1:0] op_size_t;
   typedef logic [$clog2(`AGEN_NUM_GPR)-1:0] reg_id_t;

   localparam op_size_t SIZE_BYTE = 2'd0;
   localparam op_size_t SIZE_WORD = 2'd1;
   localparam op_size_t SIZE_DWORD = 2'd2;
   localparam op_size_t SIZE_QWORD = 2'd3;

   typedef struct packed {
      logic [`AGEN_GPR_SB_W-1:0] gpr;
      logic [`AGEN_NUM_SEG-1:0] seg;
      logic [`AGEN_NUM_MM-1:0] mm;
   } scoreboard_t;

   typedef struct packed {
      // Next EIP and CS selection
      logic jmp_rel;
      logic next_eip_abs;
      logic next_cs_far;
      // Stack address control
      logic sp_push;
      logic sp_pop_multi;
      logic sp_use_temp;
      // Memory address control
      logic base_en;
      logic disp_en;
      logic sib_en;
      logic seg_use_cs;
      logic [1:0] sib_scale;
      // Source needs
      logic sr1_needed;
      logic sr2_needed;
      logic seg1_needed;
      logic seg2_needed;
      logic mm1_needed;
      logic mm2_needed;
      // Destination control
      logic ld_gpr1;
      logic ld_gpr2;
      logic ld_seg;
      logic ld_mm;
      logic drid1_sel;
   } agen_uop_t;

   // Lane bits touched by one GPR access
   // Bit index is reg * 3 + lane
   function automatic logic [`AGEN_GPR_SB_W-1:0] gpr_lanes(reg_id_t id, op_size_t size);
      logic [2:0] lanes;
      reg_id_t idx;
      lanes = 3'b111;
      idx = id;
      if (size == SIZE_BYTE) begin
         // AH, CH, DH, BH live in lane 1 of registers 0..3
         idx = {1'b0, id[1:0]};
         lanes = id[2] ? 3'b010 : 3'b001;
      end else if (size == SIZE_WORD) begin
         lanes = 3'b011;
      end
      return {{(`AGEN_GPR_SB_W - 3){1'b0}}, lanes} << (idx * 3);
   endfunction

endpackage

`default_nettype wire

/* sb_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

// One scoreboard travelling with a micro-op
interface sb_if;
   logic valid;
   logic [`AGEN_GPR_SB_W-1:0] gpr;
   logic [`AGEN_NUM_SEG-1:0] seg;
   logic [`AGEN_NUM_MM-1:0] mm;

   modport src (
      output valid, gpr, seg, mm
   );

   modport dst (
      input valid, gpr, seg, mm
   );
endinterface

`default_nettype wire

/* scoreboard_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

module scoreboard_gen (
   input logic v,
   input logic ld_gpr1,
   input logic ld_gpr2,
   input logic ld_seg,
   input logic ld_mm,
   input agen_pkg::reg_id_t drid1,
   input agen_pkg::reg_id_t drid2,
   input agen_pkg::op_size_t dr1_size,
   input agen_pkg::op_size_t dr2_size,
   sb_if.src sb
);
   import agen_pkg::*;

   logic [`AGEN_GPR_SB_W-1:0] gpr_bits;
   logic [`AGEN_NUM_SEG-1:0] seg_bits;
   logic [`AGEN_NUM_MM-1:0] mm_bits;

   always_comb begin
      gpr_bits = '0;
      seg_bits = '0;
      mm_bits = '0;
      // An idle stage claims no registers
      if (v) begin
         if (ld_gpr1) begin
            gpr_bits = gpr_bits | gpr_lanes(drid1, dr1_size);
         end
         if (ld_gpr2) begin
            gpr_bits = gpr_bits | gpr_lanes(drid2, dr2_size);
         end
         // Segment and MMX writes always target the first destination
         seg_bits[drid1] = ld_seg;
         mm_bits[drid1] = ld_mm;
      end
   end

   assign sb.valid = v;
   assign sb.gpr = gpr_bits;
   assign sb.seg = seg_bits;
   assign sb.mm = mm_bits;

endmodule

`default_nettype wire

/* dep_check.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

module dep_check (
   input logic v,
   input agen_pkg::reg_id_t sr1,
   input agen_pkg::reg_id_t sr2,
   input agen_pkg::reg_id_t sib_i,
   input agen_pkg::reg_id_t seg1,
   input agen_pkg::reg_id_t seg2,
   input agen_pkg::op_size_t sr1_size,
   input agen_pkg::op_size_t sr2_size,
   input logic sr1_needed,
   input logic sr2_needed,
   input logic seg1_needed,
   input logic seg2_needed,
   input logic mm1_needed,
   input logic mm2_needed,
   input logic sib_en,
   sb_if.dst inflight [`AGEN_INFLIGHT],
   output logic stall
);
   import agen_pkg::*;

   logic [`AGEN_GPR_SB_W-1:0] src_gpr;
   logic [`AGEN_NUM_SEG-1:0] src_seg;
   logic [`AGEN_NUM_MM-1:0] src_mm;
   logic [`AGEN_INFLIGHT-1:0] hit;

   // Registers this micro-op reads
   always_comb begin
      src_gpr = '0;
      src_seg = '0;
      src_mm = '0;
      if (sr1_needed) src_gpr = src_gpr | gpr_lanes(sr1, sr1_size);
      if (sr2_needed) src_gpr = src_gpr | gpr_lanes(sr2, sr2_size);
      // Index register is always read as 32 bits
      if (sib_en) src_gpr = src_gpr | gpr_lanes(sib_i, SIZE_DWORD);
      if (seg1_needed) src_seg[seg1] = 1'b1;
      if (seg2_needed) src_seg[seg2] = 1'b1;
      if (mm1_needed) src_mm[sr1] = 1'b1;
      if (mm2_needed) src_mm[sr2] = 1'b1;
   end

   for (genvar i = 0; i < `AGEN_INFLIGHT; i++) begin : g_slot
      assign hit[i] = inflight[i].valid &
                      (|(inflight[i].gpr & src_gpr) |
                       |(inflight[i].seg & src_seg) |
                       |(inflight[i].mm & src_mm));
   end

   assign stall = v & (|hit);

endmodule

`default_nettype wire

/* stack_addr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_addr_unit (
   input logic clk,
   input logic reset,
   input logic v,
   input logic sp_push,
   input logic sp_pop_multi,
   input logic sp_use_temp,
   input agen_pkg::op_size_t mem_size,
   input logic [31:0] sr2_data,
   output logic [31:0] sp_addr
);
   import agen_pkg::*;

   logic [3:0] push_size;
   logic [3:0] pop_size;
   logic [3:0] prev_pop_size;
   logic [31:0] temp_sp;
   logic [31:0] sp_base;
   logic [31:0] sp_addend;

   // Byte stack accesses move the pointer by a word
   always_comb begin
      case (mem_size)
         SIZE_DWORD: push_size = 4'd4;
         SIZE_QWORD: push_size = 4'd8;
         default: push_size = 4'd2;
      endcase
      pop_size = push_size;
   end

   assign sp_base = sp_use_temp ? temp_sp : sr2_data;

   always_comb begin
      if (!sp_push) begin
         sp_addend = '0;
      end else if (sp_pop_multi) begin
         // Multi-access pops walk up by the size of the previous access
         sp_addend = {28'h0, prev_pop_size};
      end else begin
         sp_addend = -{28'h0, push_size};
      end
   end

   assign sp_addr = sp_base + sp_addend;

   always_ff @(posedge clk) begin
      if (reset) begin
         temp_sp <= '0;
         prev_pop_size <= '0;
      end else if (v) begin
         temp_sp <= sp_addr;
         prev_pop_size <= pop_size;
      end
   end

endmodule

`default_nettype wire

/* agen_stage1.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

module agen_stage1 (
   input logic clk,
   input logic reset,
   input logic v,
   input agen_pkg::agen_uop_t uop,
   input logic [31:0] eip,
   input logic [15:0] cs,
   input logic [47:0] offset,
   input agen_pkg::op_size_t mem_size,
   input agen_pkg::reg_id_t sr1,
   input agen_pkg::reg_id_t sr2,
   input agen_pkg::reg_id_t sib_i,
   input agen_pkg::reg_id_t seg1,
   input agen_pkg::reg_id_t seg2,
   input agen_pkg::op_size_t sr1_size,
   input agen_pkg::op_size_t sr2_size,
   input agen_pkg::op_size_t dr1_size,
   input agen_pkg::op_size_t dr2_size,
   input logic [31:0] sr1_data,
   input logic [31:0] sr2_data,
   input logic [31:0] sib_i_data,
   input logic [31:0] disp32,
   input logic [15:0] seg1_data,
   input logic nmi_en,
   input logic pf_en,
   input logic gp_en,
   output logic [31:0] next_eip,
   output logic [15:0] next_cs,
   output logic [31:0] base_disp,
   output logic [31:0] sib_seg,
   output logic [31:0] sp_addr,
   output logic [31:0] int_addr,
   output logic exc_v,
   output logic stall,
   sb_if.src sb_out,
   sb_if.dst inflight [`AGEN_INFLIGHT]
);
   import agen_pkg::*;

   logic [31:0] base_term;
   logic [31:0] disp_term;
   logic [31:0] sib_term;
   logic [15:0] seg_sel;
   reg_id_t drid1;
   reg_id_t drid2;

   // Base plus displacement half of the effective address
   assign base_term = uop.base_en ? sr1_data : '0;
   assign disp_term = uop.disp_en ? disp32 : '0;
   assign base_disp = base_term + disp_term;

   // Segment base plus scaled index half
   assign seg_sel = uop.seg_use_cs ? cs : seg1_data;
   assign sib_term = uop.sib_en ? (sib_i_data << uop.sib_scale) : '0;
   assign sib_seg = {seg_sel, 16'h0000} + sib_term;

   // Absolute target wins over relative, otherwise fall through
   always_comb begin
      if (uop.next_eip_abs) begin
         next_eip = offset[31:0];
      end else if (uop.jmp_rel) begin
         next_eip = eip + offset[31:0];
      end else begin
         next_eip = eip;
      end
   end

   assign next_cs = uop.next_cs_far ? offset[47:32] : cs;

   // NMI over page fault over general protection
   always_comb begin
      if (nmi_en) begin
         int_addr = `AGEN_NMI_VECTOR;
      end else if (pf_en) begin
         int_addr = `AGEN_PF_VECTOR;
      end else if (gp_en) begin
         int_addr = `AGEN_GP_VECTOR;
      end else begin
         int_addr = '0;
      end
   end

   assign exc_v = v & (nmi_en | pf_en | gp_en);

   assign drid1 = uop.drid1_sel ? sr1 : sr2;
   assign drid2 = sr2;

   stack_addr_unit u_stack_addr_unit (
      .clk          (clk),
      .reset        (reset),
      .v            (v),
      .sp_push      (uop.sp_push),
      .sp_pop_multi (uop.sp_pop_multi),
      .sp_use_temp  (uop.sp_use_temp),
      .mem_size     (mem_size),
      .sr2_data     (sr2_data),
      .sp_addr      (sp_addr)
   );

   scoreboard_gen u_scoreboard_gen (
      .v        (v),
      .ld_gpr1  (uop.ld_gpr1),
      .ld_gpr2  (uop.ld_gpr2),
      .ld_seg   (uop.ld_seg),
      .ld_mm    (uop.ld_mm),
      .drid1    (drid1),
      .drid2    (drid2),
      .dr1_size (dr1_size),
      .dr2_size (dr2_size),
      .sb       (sb_out)
   );

   dep_check u_dep_check (
      .v           (v),
      .sr1         (sr1),
      .sr2         (sr2),
      .sib_i       (sib_i),
      .seg1        (seg1),
      .seg2        (seg2),
      .sr1_size    (sr1_size),
      .sr2_size    (sr2_size),
      .sr1_needed  (uop.sr1_needed),
      .sr2_needed  (uop.sr2_needed),
      .seg1_needed (uop.seg1_needed),
      .seg2_needed (uop.seg2_needed),
      .mm1_needed  (uop.mm1_needed),
      .mm2_needed  (uop.mm2_needed),
      .sib_en      (uop.sib_en),
      .inflight    (inflight),
      .stall       (stall)
   );

endmodule

`default_nettype wire

/* inflight_pipe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

module inflight_pipe (
   input logic clk,
   input logic reset,
   input logic stall,
   sb_if.dst sb_in,
   sb_if.src stages [`AGEN_INFLIGHT]
);
   import agen_pkg::*;

   logic [`AGEN_INFLIGHT-1:0] valid_q;
   scoreboard_t slot_q [`AGEN_INFLIGHT];

   // A stalled micro-op enters as a bubble and is presented again
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[`AGEN_INFLIGHT-2:0], sb_in.valid & ~stall};
      end
   end

   always_ff @(posedge clk) begin
      slot_q[0] <= '{gpr: sb_in.gpr, seg: sb_in.seg, mm: sb_in.mm};
      for (int i = 1; i < `AGEN_INFLIGHT; i++) begin
         slot_q[i] <= slot_q[i-1];
      end
   end

   // Slot 0 is AG2 and the last slot is EX
   for (genvar i = 0; i < `AGEN_INFLIGHT; i++) begin : g_stage
      assign stages[i].valid = valid_q[i];
      assign stages[i].gpr = slot_q[i].gpr;
      assign stages[i].seg = slot_q[i].seg;
      assign stages[i].mm = slot_q[i].mm;
   end

   // An idle source offers an empty scoreboard
   a_idle_empty: assert property (@(posedge clk) disable iff (reset)
      !sb_in.valid |-> (sb_in.gpr == '0 && sb_in.seg == '0 && sb_in.mm == '0))
      else $error("inflight_pipe: idle source with a non-empty scoreboard");

   // Only a held micro-op can be stalled
   a_stall_held: assert property (@(posedge clk) disable iff (reset)
      stall |-> sb_in.valid)
      else $error("inflight_pipe: stall without a held micro-op");

endmodule

`default_nettype wire

/* agen_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

module agen_top (
   input logic clk,
   input logic reset,
   input logic v,
   input agen_pkg::agen_uop_t uop,
   input logic [31:0] eip,
   input logic [15:0] cs,
   input logic [47:0] offset,
   input agen_pkg::op_size_t mem_size,
   input agen_pkg::reg_id_t sr1,
   input agen_pkg::reg_id_t sr2,
   input agen_pkg::reg_id_t sib_i,
   input agen_pkg::reg_id_t seg1,
   input agen_pkg::reg_id_t seg2,
   input agen_pkg::op_size_t sr1_size,
   input agen_pkg::op_size_t sr2_size,
   input agen_pkg::op_size_t dr1_size,
   input agen_pkg::op_size_t dr2_size,
   input logic [31:0] sr1_data,
   input logic [31:0] sr2_data,
   input logic [31:0] sib_i_data,
   input logic [31:0] disp32,
   input logic [15:0] seg1_data,
   input logic nmi_en,
   input logic pf_en,
   input logic gp_en,
   output logic [31:0] next_eip,
   output logic [15:0] next_cs,
   output logic [31:0] base_disp,
   output logic [31:0] sib_seg,
   output logic [31:0] sp_addr,
   output logic [31:0] int_addr,
   output logic exc_v,
   output logic stall
);

   // Issued scoreboard and the four stages ahead of it
   sb_if sb_issue ();
   sb_if sb_stage [`AGEN_INFLIGHT] ();

   agen_stage1 u_agen_stage1 (
      .clk        (clk),
      .reset      (reset),
      .v          (v),
      .uop        (uop),
      .eip        (eip),
      .cs         (cs),
      .offset     (offset),
      .mem_size   (mem_size),
      .sr1        (sr1),
      .sr2        (sr2),
      .sib_i      (sib_i),
      .seg1       (seg1),
      .seg2       (seg2),
      .sr1_size   (sr1_size),
      .sr2_size   (sr2_size),
      .dr1_size   (dr1_size),
      .dr2_size   (dr2_size),
      .sr1_data   (sr1_data),
      .sr2_data   (sr2_data),
      .sib_i_data (sib_i_data),
      .disp32     (disp32),
      .seg1_data  (seg1_data),
      .nmi_en     (nmi_en),
      .pf_en      (pf_en),
      .gp_en      (gp_en),
      .next_eip   (next_eip),
      .next_cs    (next_cs),
      .base_disp  (base_disp),
      .sib_seg    (sib_seg),
      .sp_addr    (sp_addr),
      .int_addr   (int_addr),
      .exc_v      (exc_v),
      .stall      (stall),
      .sb_out     (sb_issue),
      .inflight   (sb_stage)
   );

   inflight_pipe u_inflight_pipe (
      .clk    (clk),
      .reset  (reset),
      .stall  (stall),
      .sb_in  (sb_issue),
      .stages (sb_stage)
   );

endmodule

`default_nettype wire

/* tb_agen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "agen_defs.svh"

module tb_agen;
   import agen_pkg::*;

   localparam logic [31:0] rand_seed = 32'h75e81eec;
   localparam int n_cycles = 200;
   localparam int window_limit = 10;

   logic clk;
   logic reset;
   logic v;
   agen_uop_t uop;
   logic [31:0] eip;
   logic [15:0] cs;
   logic [47:0] offset;
   op_size_t mem_size;
   reg_id_t sr1;
   reg_id_t sr2;
   reg_id_t sib_i;
   reg_id_t seg1;
   reg_id_t seg2;
   op_size_t sr1_size;
   op_size_t sr2_size;
   op_size_t dr1_size;
   op_size_t dr2_size;
   logic [31:0] sr1_data;
   logic [31:0] sr2_data;
   logic [31:0] sib_i_data;
   logic [31:0] disp32;
   logic [15:0] seg1_data;
   logic nmi_en;
   logic pf_en;
   logic gp_en;
   logic [31:0] next_eip;
   logic [15:0] next_cs;
   logic [31:0] base_disp;
   logic [31:0] sib_seg;
   logic [31:0] sp_addr;
   logic [31:0] int_addr;
   logic exc_v;
   logic stall;

   // Reference model state
   logic q_valid [`AGEN_INFLIGHT];
   logic [`AGEN_GPR_SB_W-1:0] q_gpr [`AGEN_INFLIGHT];
   logic [`AGEN_NUM_SEG-1:0] q_seg [`AGEN_INFLIGHT];
   logic [`AGEN_NUM_MM-1:0] q_mm [`AGEN_INFLIGHT];
   logic [31:0] m_temp;
   logic [3:0] m_prev_pop;

   int test_errors;
   int total_errors;
   int tests_run;
   int tests_failed;
   logic seen_stall;

   agen_top u_agen_top (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Byte regs 4..7 are the high bytes of regs 0..3
   function automatic logic [`AGEN_GPR_SB_W-1:0] lane_bits(input logic [2:0] id,
                                                            input logic [1:0] size);
      logic [`AGEN_GPR_SB_W-1:0] m;
      m = '0;
      if (size == 2'd0) begin
         if (id < 3'd4) begin
            m[id * 3] = 1'b1;
         end else begin
            m[(id - 4) * 3 + 1] = 1'b1;
         end
      end else if (size == 2'd1) begin
         m[id * 3 +: 2] = 2'b11;
      end else begin
         m[id * 3 +: 3] = 3'b111;
      end
      return m;
   endfunction

   function automatic logic [3:0] step_bytes(input logic [1:0] size);
      if (size == 2'd2) begin
         return 4'd4;
      end else if (size == 2'd3) begin
         return 4'd8;
      end
      return 4'd2;
   endfunction

   function automatic logic [31:0] predict_sp();
      logic [31:0] base;
      logic [31:0] addend;
      base = uop.sp_use_temp ? m_temp : sr2_data;
      addend = 32'h0;
      if (uop.sp_push && uop.sp_pop_multi) begin
         addend = {28'h0, m_prev_pop};
      end else if (uop.sp_push) begin
         addend = 32'h0 - {28'h0, step_bytes(mem_size)};
      end
      return base + addend;
   endfunction

   function automatic logic predict_stall();
      logic [`AGEN_GPR_SB_W-1:0] sg;
      logic [`AGEN_NUM_SEG-1:0] ss;
      logic [`AGEN_NUM_MM-1:0] sm;
      logic hit;
      sg = '0;
      ss = '0;
      sm = '0;
      hit = 1'b0;
      if (uop.sr1_needed) sg = sg | lane_bits(sr1, sr1_size);
      if (uop.sr2_needed) sg = sg | lane_bits(sr2, sr2_size);
      if (uop.sib_en) sg = sg | lane_bits(sib_i, 2'd2);
      if (uop.seg1_needed) ss[seg1] = 1'b1;
      if (uop.seg2_needed) ss[seg2] = 1'b1;
      if (uop.mm1_needed) sm[sr1] = 1'b1;
      if (uop.mm2_needed) sm[sr2] = 1'b1;
      for (int i = 0; i < `AGEN_INFLIGHT; i++) begin
         if (q_valid[i] && (|(q_gpr[i] & sg) || |(q_seg[i] & ss) || |(q_mm[i] & sm))) begin
            hit = 1'b1;
         end
      end
      return v & hit;
   endfunction

   task automatic check_value(input string name, input logic [47:0] got,
                              input logic [47:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_outputs();
      logic [31:0] e_bd;
      logic [31:0] e_ss;
      logic [31:0] e_eip;
      logic [31:0] e_int;
      e_bd = (uop.base_en ? sr1_data : 32'h0) + (uop.disp_en ? disp32 : 32'h0);
      e_ss = {(uop.seg_use_cs ? cs : seg1_data), 16'h0} +
             (uop.sib_en ? (sib_i_data << uop.sib_scale) : 32'h0);
      e_eip = uop.next_eip_abs ? offset[31:0] : (uop.jmp_rel ? eip + offset[31:0] : eip);
      e_int = nmi_en ? `AGEN_NMI_VECTOR : (pf_en ? `AGEN_PF_VECTOR :
              (gp_en ? `AGEN_GP_VECTOR : 32'h0));
      check_value("base_disp", 48'(base_disp), 48'(e_bd));
      check_value("sib_seg", 48'(sib_seg), 48'(e_ss));
      check_value("next_eip", 48'(next_eip), 48'(e_eip));
      check_value("next_cs", 48'(next_cs), 48'(uop.next_cs_far ? offset[47:32] : cs));
      check_value("sp_addr", 48'(sp_addr), 48'(predict_sp()));
      check_value("int_addr", 48'(int_addr), 48'(e_int));
      check_value("exc_v", 48'(exc_v), 48'(v & (nmi_en | pf_en | gp_en)));
      check_value("stall", 48'(stall), 48'(predict_stall()));
   endtask

   task automatic update_model();
      logic issue;
      logic [2:0] d1;
      logic [`AGEN_GPR_SB_W-1:0] g;
      logic [`AGEN_NUM_SEG-1:0] sg;
      logic [`AGEN_NUM_MM-1:0] sm;
      issue = v & ~predict_stall();
      d1 = uop.drid1_sel ? sr1 : sr2;
      g = '0;
      sg = '0;
      sm = '0;
      if (v) begin
         if (uop.ld_gpr1) g = g | lane_bits(d1, dr1_size);
         if (uop.ld_gpr2) g = g | lane_bits(sr2, dr2_size);
         sg[d1] = uop.ld_seg;
         sm[d1] = uop.ld_mm;
      end
      for (int i = `AGEN_INFLIGHT - 1; i > 0; i--) begin
         q_valid[i] = q_valid[i-1];
         q_gpr[i] = q_gpr[i-1];
         q_seg[i] = q_seg[i-1];
         q_mm[i] = q_mm[i-1];
      end
      // Stalled micro-ops go in as bubbles
      q_valid[0] = issue;
      q_gpr[0] = g;
      q_seg[0] = sg;
      q_mm[0] = sm;
      if (v) begin
         m_temp = predict_sp();
         m_prev_pop = step_bytes(mem_size);
      end
   endtask

   task automatic reset_model();
      for (int i = 0; i < `AGEN_INFLIGHT; i++) begin
         q_valid[i] = 1'b0;
         q_gpr[i] = '0;
         q_seg[i] = '0;
         q_mm[i] = '0;
      end
      m_temp = 32'h0;
      m_prev_pop = 4'h0;
   endtask

   task automatic clear_inputs();
      v = 1'b0;
      uop = '0;
      eip = 32'h0;
      cs = 16'h0;
      offset = 48'h0;
      mem_size = SIZE_BYTE;
      sr1 = '0;
      sr2 = '0;
      sib_i = '0;
      seg1 = '0;
      seg2 = '0;
      sr1_size = SIZE_BYTE;
      sr2_size = SIZE_BYTE;
      dr1_size = SIZE_BYTE;
      dr2_size = SIZE_BYTE;
      sr1_data = 32'h0;
      sr2_data = 32'h0;
      sib_i_data = 32'h0;
      disp32 = 32'h0;
      seg1_data = 16'h0;
      nmi_en = 1'b0;
      pf_en = 1'b0;
      gp_en = 1'b0;
   endtask

   task automatic randomize_inputs(input int unsigned v_pct);
      logic [31:0] r;
      r = $urandom;
      uop = r[$bits(agen_uop_t)-1:0];
      v = ($urandom % 100) < v_pct;
      eip = $urandom;
      cs = 16'($urandom);
      offset = {16'($urandom), $urandom};
      mem_size = op_size_t'($urandom % 4);
      // Few register ids so that producers and readers meet often
      sr1 = reg_id_t'($urandom % 6);
      sr2 = reg_id_t'($urandom % 6);
      sib_i = reg_id_t'($urandom % 6);
      seg1 = reg_id_t'($urandom % 4);
      seg2 = reg_id_t'($urandom % 4);
      sr1_size = op_size_t'($urandom % 4);
      sr2_size = op_size_t'($urandom % 4);
      dr1_size = op_size_t'($urandom % 4);
      dr2_size = op_size_t'($urandom % 4);
      sr1_data = $urandom;
      sr2_data = $urandom;
      sib_i_data = $urandom;
      disp32 = $urandom;
      seg1_data = 16'($urandom);
      nmi_en = ($urandom % 5) == 0;
      pf_en = ($urandom % 4) == 0;
      gp_en = ($urandom % 3) == 0;
   endtask

   // Inputs are set at the falling edge and checked just before the rising one
   task automatic run_cycle();
      #40;
      check_outputs();
      seen_stall = stall;
      @(posedge clk);
      update_model();
      @(negedge clk);
   endtask

   task automatic apply_reset();
      clear_inputs();
      reset = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      reset_model();
   endtask

   task automatic random_test(input string name, input int unsigned v_pct);
      repeat (n_cycles) begin
         randomize_inputs(v_pct);
         run_cycle();
      end
      finish_test(name);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("test %0d %s: %s, %0d errors", tests_run, name,
               (test_errors == 0) ? "ok" : "FAIL", test_errors);
      total_errors += test_errors;
      test_errors = 0;
   endtask

   initial begin
      int stall_cycles;
      logic cleared;
      void'($urandom(rand_seed));
      test_errors = 0;
      total_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      seen_stall = 1'b0;
      reset_model();
      apply_reset();

      random_test("address", 50);
      random_test("next_eip", 60);
      // Long runs of valid micro-ops exercise the temp pointer
      random_test("stack", 90);
      random_test("interrupt", 50);

      // Every source needed right after reset with nothing in flight yet
      apply_reset();
      randomize_inputs(100);
      uop.sr1_needed = 1'b1;
      uop.sr2_needed = 1'b1;
      uop.seg1_needed = 1'b1;
      uop.mm1_needed = 1'b1;
      run_cycle();
      if (seen_stall !== 1'b0) begin
         $display("mismatch at %0t ns: stall got %b expected 0", $time, seen_stall);
         test_errors++;
      end
      random_test("stall", 80);

      // One dword write to reg 2 and then a reader held until it issues
      clear_inputs();
      repeat (`AGEN_INFLIGHT) run_cycle();
      v = 1'b1;
      uop.ld_gpr1 = 1'b1;
      uop.drid1_sel = 1'b1;
      sr1 = reg_id_t'(2);
      dr1_size = SIZE_DWORD;
      run_cycle();
      uop = '0;
      uop.sr1_needed = 1'b1;
      sr1_size = SIZE_DWORD;
      stall_cycles = 0;
      cleared = 1'b0;
      for (int n = 0; n < window_limit && !cleared; n++) begin
         run_cycle();
         if (seen_stall) begin
            stall_cycles++;
         end else begin
            cleared = 1'b1;
         end
      end
      if (!cleared) begin
         $display("stall did not clear within %0d cycles of the write", window_limit);
         test_errors++;
      end else if (stall_cycles != `AGEN_INFLIGHT) begin
         $display("mismatch at %0t ns: stall_cycles got %0d expected %0d", $time,
                  stall_cycles, `AGEN_INFLIGHT);
         test_errors++;
      end
      finish_test("window");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
      if (tests_failed == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
agen_pkg.sv
sb_if.sv
scoreboard_gen.sv
dep_check.sv
stack_addr_unit.sv
agen_stage1.sv
inflight_pipe.sv
agen_top.sv
tb_agen.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_agen
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
